/* run_sim.sh */
#!/bin/sh
# build and run the UART loopback testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -j 0 \
    --top-module uart_loop_tb \
    -f src.f \
    -o Vuart_loop_tb

# an assertion stop still leaves the log for the search below
./obj_dir/Vuart_loop_tb > sim.log 2>&1 || true
cat sim.log

if grep -qx "sim passed" sim.log; then
    echo "result: pass"
else
    echo "result: fail"
    exit 1
fi

/* src.f */
src/uart_loop_pkg.sv
src/uart_cfg_regs.sv
src/uart_rx.sv
src/uart_tx.sv
src/loop_ctrl.sv
src/uart_loop_top.sv
test/uart_loop_asserts.sv
test/uart_loop_tb.sv

/* src/loop_ctrl.sv */
`timescale 1ns/1ps

module loop_ctrl (
    input  logic                             clk,
    input  logic                             rst,
    input  uart_loop_pkg::uart_cfg_t         cfg,
    input  uart_loop_pkg::rx_status_t        rx_stat,
    input  logic                             tx_busy,
    output logic                             tx_start,
    output logic [uart_loop_pkg::DATA_W-1:0] tx_data,
    output logic [uart_loop_pkg::CNT_W-1:0]  parity_drops,
    output logic [uart_loop_pkg::CNT_W-1:0]  overrun_drops
);

    uart_loop_pkg::loop_state_e        state;
    logic [uart_loop_pkg::DATA_W-1:0]  echo_q;
    logic [uart_loop_pkg::GAP_W-1:0]   gap_cnt;
    // delayed busy for falling-edge detect
    logic                              busy_q;
    logic                              good_byte;
    logic                              bad_byte;
    logic                              tx_done;

    // counters stick at all-ones
    function automatic logic [uart_loop_pkg::CNT_W-1:0] sat_inc(
        input logic [uart_loop_pkg::CNT_W-1:0] v
    );
        return (&v) ? v : v + 1'b1;
    endfunction

    assign bad_byte  = rx_stat.done && rx_stat.parity_err;
    // loopback off hides good bytes from the FSM and the overrun count
    assign good_byte = rx_stat.done && !rx_stat.parity_err && cfg.loop_en;
    // busy rises a cycle after the start strobe, so wait for its fall
    assign tx_done   = busy_q && !tx_busy;

    assign tx_start = (state == uart_loop_pkg::LOOP_START);
    assign tx_data  = echo_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            state   <= uart_loop_pkg::LOOP_IDLE;
            gap_cnt <= '0;
            busy_q  <= 1'b0;
        end else begin
            busy_q <= tx_busy;
            case (state)
                uart_loop_pkg::LOOP_IDLE: begin
                    if (good_byte) begin
                        echo_q <= rx_stat.data;
                        state  <= uart_loop_pkg::LOOP_START;
                    end
                end
                uart_loop_pkg::LOOP_START: begin
                    // single-cycle strobe to the transmitter
                    state <= uart_loop_pkg::LOOP_BUSY;
                end
                uart_loop_pkg::LOOP_BUSY: begin
                    if (tx_done) begin
                        gap_cnt <= '0;
                        state   <= uart_loop_pkg::LOOP_GAP;
                    end
                end
                uart_loop_pkg::LOOP_GAP: begin
                    // gap of 0 spends one cycle here
                    if (gap_cnt >= cfg.gap) begin
                        state <= uart_loop_pkg::LOOP_IDLE;
                    end else begin
                        gap_cnt <= gap_cnt + 1'b1;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            parity_drops  <= '0;
            overrun_drops <= '0;
        end else begin
            // parity failures count in every state
            if (bad_byte) begin
                parity_drops <= sat_inc(parity_drops);
            end
            // good byte while an echo is still in flight
            if (good_byte && (state != uart_loop_pkg::LOOP_IDLE)) begin
                overrun_drops <= sat_inc(overrun_drops);
            end
        end
    end

endmodule

/* src/uart_cfg_regs.sv */
`timescale 1ns/1ps

module uart_cfg_regs (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      cfg_we,
    input  uart_loop_pkg::cfg_addr_e  cfg_addr,
    input  logic [7:0]                cfg_wdata,
    output uart_loop_pkg::uart_cfg_t  cfg
);

    uart_loop_pkg::parity_mode_e       parity_q;
    logic [uart_loop_pkg::GAP_W-1:0]   gap_q;
    logic                              loop_en_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            // no parity, no gap, echo on
            parity_q  <= uart_loop_pkg::PARITY_NONE;
            gap_q     <= '0;
            loop_en_q <= 1'b1;
        end else if (cfg_we) begin
            case (cfg_addr)
                uart_loop_pkg::CFG_PARITY: begin
                    // unknown code falls back to no parity
                    case (cfg_wdata[1:0])
                        uart_loop_pkg::PARITY_EVEN: parity_q <= uart_loop_pkg::PARITY_EVEN;
                        uart_loop_pkg::PARITY_ODD:  parity_q <= uart_loop_pkg::PARITY_ODD;
                        default:                    parity_q <= uart_loop_pkg::PARITY_NONE;
                    endcase
                end
                uart_loop_pkg::CFG_GAP: begin
                    gap_q <= cfg_wdata[uart_loop_pkg::GAP_W-1:0];
                end
                uart_loop_pkg::CFG_CTRL: begin
                    // bit 0 is the loopback enable
                    loop_en_q <= cfg_wdata[0];
                end
                default: begin
                    // unmapped address, write ignored
                end
            endcase
        end
    end

    // settings shared by rx, tx and the controller
    assign cfg = '{parity: parity_q, gap: gap_q, loop_en: loop_en_q};

endmodule

/* src/uart_loop_pkg.sv */
package uart_loop_pkg;

    // frame geometry
    localparam int DATA_W = 8;
    localparam int DATA_IDX_W = $clog2(DATA_W);
    localparam logic [DATA_IDX_W-1:0] DATA_LAST = DATA_IDX_W'(DATA_W - 1);

    // 24 MHz clock, 6 Mbaud line
    localparam int CLKS_PER_BIT = 4;
    localparam int BIT_CNT_W = $clog2(CLKS_PER_BIT);
    localparam logic [BIT_CNT_W-1:0] BIT_LAST = BIT_CNT_W'(CLKS_PER_BIT - 1);
    // receiver lands its samples near the bit centre
    localparam logic [BIT_CNT_W-1:0] HALF_LAST = BIT_CNT_W'(CLKS_PER_BIT / 2 - 1);

    // start + data + parity + stop
    localparam int FRAME_MAX = DATA_W + 3;
    localparam int IDX_W = $clog2(FRAME_MAX);
    // index of the stop bit inside the transmit shift register
    localparam logic [IDX_W-1:0] STOP_IDX_NOPAR = IDX_W'(DATA_W + 1);
    localparam logic [IDX_W-1:0] STOP_IDX_PAR = IDX_W'(DATA_W + 2);

    // config and status widths
    localparam int GAP_W = 8;
    localparam int CNT_W = 8;

    typedef enum logic [1:0] {
        PARITY_NONE = 2'd0,
        PARITY_EVEN = 2'd1,
        PARITY_ODD  = 2'd2
    } parity_mode_e;

    // register map of the config block
    typedef enum logic [1:0] {
        CFG_PARITY = 2'd0,
        CFG_GAP    = 2'd1,
        CFG_CTRL   = 2'd2
    } cfg_addr_e;

    typedef enum logic [1:0] {
        LOOP_IDLE  = 2'd0,
        LOOP_START = 2'd1,
        LOOP_BUSY  = 2'd2,
        LOOP_GAP   = 2'd3
    } loop_state_e;

    typedef struct packed {
        parity_mode_e     parity;
        logic [GAP_W-1:0] gap;
        logic             loop_en;
    } uart_cfg_t;

    // parity_err only meaningful together with done
    typedef struct packed {
        logic [DATA_W-1:0] data;
        logic              done;
        logic              parity_err;
    } rx_status_t;

endpackage

/* src/uart_loop_top.sv */
`timescale 1ns/1ps

module uart_loop_top (
    input  logic                             clk,
    input  logic                             rst,
    input  logic                             rx,
    output logic                             tx,
    input  logic                             cfg_we,
    input  uart_loop_pkg::cfg_addr_e         cfg_addr,
    input  logic [7:0]                       cfg_wdata,
    output logic                             tx_busy,
    output logic [uart_loop_pkg::CNT_W-1:0]  parity_drops,
    output logic [uart_loop_pkg::CNT_W-1:0]  overrun_drops
);

    // settings fan out to all three blocks
    uart_loop_pkg::uart_cfg_t          cfg;
    uart_loop_pkg::rx_status_t         rx_stat;
    logic                              tx_start;
    logic [uart_loop_pkg::DATA_W-1:0]  tx_data;

    uart_cfg_regs cfg_regs_i (
        .clk       (clk),
        .rst       (rst),
        .cfg_we    (cfg_we),
        .cfg_addr  (cfg_addr),
        .cfg_wdata (cfg_wdata),
        .cfg       (cfg)
    );

    uart_rx rx_i (
        .clk     (clk),
        .rst     (rst),
        .rx      (rx),
        .cfg     (cfg),
        .rx_stat (rx_stat)
    );

    // echo decision and drop counters
    loop_ctrl loop_ctrl_i (
        .clk           (clk),
        .rst           (rst),
        .cfg           (cfg),
        .rx_stat       (rx_stat),
        .tx_busy       (tx_busy),
        .tx_start      (tx_start),
        .tx_data       (tx_data),
        .parity_drops  (parity_drops),
        .overrun_drops (overrun_drops)
    );

    uart_tx tx_i (
        .clk      (clk),
        .rst      (rst),
        .tx_start (tx_start),
        .tx_data  (tx_data),
        .cfg      (cfg),
        .tx       (tx),
        .tx_busy  (tx_busy)
    );

endmodule

/* src/uart_rx.sv */
`timescale 1ns/1ps

module uart_rx (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       rx,
    input  uart_loop_pkg::uart_cfg_t   cfg,
    output uart_loop_pkg::rx_status_t  rx_stat
);

    typedef enum logic [2:0] {
        RX_IDLE,
        RX_START,
        RX_DATA,
        RX_PAR,
        RX_STOP
    } rx_state_e;

    rx_state_e                            state;
    // two-flop synchronizer plus one flop for edge detect
    logic                                 rx_s1;
    logic                                 rx_s2;
    logic                                 rx_q;
    logic [uart_loop_pkg::BIT_CNT_W-1:0]  clk_cnt;
    logic [uart_loop_pkg::DATA_IDX_W-1:0] bit_idx;
    logic [uart_loop_pkg::DATA_W-1:0]     data_sh;
    uart_loop_pkg::parity_mode_e          par_mode;
    logic                                 par_bit;
    logic                                 exp_par;
    logic                                 bit_tick;
    logic                                 done_q;
    logic                                 perr_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            rx_s1 <= 1'b1;
            rx_s2 <= 1'b1;
            rx_q  <= 1'b1;
        end else begin
            rx_s1 <= rx;
            rx_s2 <= rx_s1;
            rx_q  <= rx_s2;
        end
    end

    // one sample per bit time after the start check
    assign bit_tick = (clk_cnt == uart_loop_pkg::BIT_LAST);
    // parity expected for the shifted-in byte
    assign exp_par = (par_mode == uart_loop_pkg::PARITY_ODD) ? ~(^data_sh) : (^data_sh);

    always_ff @(posedge clk) begin
        if (rst) begin
            state   <= RX_IDLE;
            clk_cnt <= '0;
            bit_idx <= '0;
            done_q  <= 1'b0;
            perr_q  <= 1'b0;
        end else begin
            done_q <= 1'b0;
            case (state)
                RX_IDLE: begin
                    clk_cnt <= '0;
                    bit_idx <= '0;
                    // falling edge on the synchronized line
                    if (rx_q && !rx_s2) begin
                        state    <= RX_START;
                        par_mode <= cfg.parity;
                    end
                end
                RX_START: begin
                    if (clk_cnt == uart_loop_pkg::HALF_LAST) begin
                        clk_cnt <= '0;
                        // still low at mid-bit, else a glitch
                        state   <= rx_s2 ? RX_IDLE : RX_DATA;
                    end else begin
                        clk_cnt <= clk_cnt + 1'b1;
                    end
                end
                RX_DATA: begin
                    if (bit_tick) begin
                        clk_cnt <= '0;
                        // lsb first
                        data_sh <= {rx_s2, data_sh[uart_loop_pkg::DATA_W-1:1]};
                        if (bit_idx == uart_loop_pkg::DATA_LAST) begin
                            state <= (par_mode == uart_loop_pkg::PARITY_NONE) ? RX_STOP : RX_PAR;
                        end else begin
                            bit_idx <= bit_idx + 1'b1;
                        end
                    end else begin
                        clk_cnt <= clk_cnt + 1'b1;
                    end
                end
                RX_PAR: begin
                    if (bit_tick) begin
                        clk_cnt <= '0;
                        par_bit <= rx_s2;
                        state   <= RX_STOP;
                    end else begin
                        clk_cnt <= clk_cnt + 1'b1;
                    end
                end
                RX_STOP: begin
                    if (bit_tick) begin
                        clk_cnt <= '0;
                        state   <= RX_IDLE;
                        // low stop bit, drop the frame silently
                        if (rx_s2) begin
                            done_q <= 1'b1;
                            perr_q <= (par_mode != uart_loop_pkg::PARITY_NONE) &&
                                      (par_bit != exp_par);
                        end
                    end else begin
                        clk_cnt <= clk_cnt + 1'b1;
                    end
                end
                default: state <= RX_IDLE;
            endcase
        end
    end

    assign rx_stat = '{data: data_sh, done: done_q, parity_err: perr_q};

endmodule

/* src/uart_tx.sv */
`timescale 1ns/1ps

module uart_tx (
    input  logic                              clk,
    input  logic                              rst,
    input  logic                              tx_start,
    input  logic [uart_loop_pkg::DATA_W-1:0]  tx_data,
    input  uart_loop_pkg::uart_cfg_t          cfg,
    output logic                              tx,
    output logic                              tx_busy
);

    // whole frame, bit 0 goes out first
    logic [uart_loop_pkg::FRAME_MAX-1:0] shreg;
    logic [uart_loop_pkg::IDX_W-1:0]     bit_idx;
    logic [uart_loop_pkg::IDX_W-1:0]     stop_idx;
    logic [uart_loop_pkg::BIT_CNT_W-1:0] clk_cnt;
    // one cycle between accepting the strobe and driving the line
    logic                                load_q;
    logic                                par_en;
    logic                                par_bit;

    assign par_en = (cfg.parity != uart_loop_pkg::PARITY_NONE);
    // even mode makes the total count of ones even
    assign par_bit = (cfg.parity == uart_loop_pkg::PARITY_ODD) ? ~(^tx_data) : (^tx_data);

    always_ff @(posedge clk) begin
        if (rst) begin
            tx      <= 1'b1;
            tx_busy <= 1'b0;
            load_q  <= 1'b0;
            clk_cnt <= '0;
            bit_idx <= '0;
        end else begin
            load_q <= 1'b0;

            // capture frame and parity mode at start
            if (tx_start && !tx_busy && !load_q) begin
                load_q <= 1'b1;
                if (par_en) begin
                    shreg    <= {1'b1, par_bit, tx_data, 1'b0};
                    stop_idx <= uart_loop_pkg::STOP_IDX_PAR;
                end else begin
                    // top bit is padding, never reaches the line
                    shreg    <= {2'b11, tx_data, 1'b0};
                    stop_idx <= uart_loop_pkg::STOP_IDX_NOPAR;
                end
            end

            if (load_q) begin
                // start bit goes out here
                tx_busy <= 1'b1;
                tx      <= shreg[0];
                clk_cnt <= '0;
                bit_idx <= '0;
            end else if (tx_busy) begin
                if (clk_cnt == uart_loop_pkg::BIT_LAST) begin
                    clk_cnt <= '0;
                    if (bit_idx == stop_idx) begin
                        // end of stop bit, line stays high
                        tx_busy <= 1'b0;
                        tx      <= 1'b1;
                    end else begin
                        bit_idx <= bit_idx + 1'b1;
                        tx      <= shreg[1];
                        // shift in ones so the line idles high
                        shreg   <= {1'b1, shreg[uart_loop_pkg::FRAME_MAX-1:1]};
                    end
                end else begin
                    clk_cnt <= clk_cnt + 1'b1;
                end
            end
        end
    end

endmodule

/* test/uart_loop_asserts.sv */
`timescale 1ns/1ps

module uart_loop_asserts (
    input logic clk,
    input logic rst,
    input logic tx_start,
    input logic tx_busy,
    input logic tx
);

    // start strobe is one cycle wide
    a_start_pulse: assert property (
        @(posedge clk) disable iff (rst) tx_start |=> !tx_start
    ) else $error("tx_start high for two cycles in a row");

    // transmitter only gets a start while idle
    a_start_idle: assert property (
        @(posedge clk) disable iff (rst) tx_start |-> !tx_busy
    ) else $error("tx_start asserted while tx_busy is high");

    // line rests high between frames
    a_line_idle: assert property (
        @(posedge clk) disable iff (rst) !tx_busy |-> tx
    ) else $error("tx low while tx_busy is low");

endmodule

// controller strobe and transmitter line both meet at the top level
bind uart_loop_top uart_loop_asserts asserts_i (
    .clk      (clk),
    .rst      (rst),
    .tx_start (tx_start),
    .tx_busy  (tx_busy),
    .tx       (tx)
);

/* test/uart_loop_cases.txt */
# W addr data: config write, addr 0 parity / 1 gap / 2 ctrl (all hex)
# S byte corrupt b2b echo min_idle parity_drops overrun_drops (all hex)
S 00 0 0 1 0 00 00
S 01 0 0 1 0 00 00
S 5a 0 0 1 0 00 00
S a5 0 0 1 0 00 00
S ff 0 0 1 0 00 00
W 0 01
S 3c 0 0 1 0 00 00
S 17 0 0 1 0 00 00
W 0 02
S 3c 0 0 1 0 00 00
S 81 0 0 1 0 00 00
S 5a 1 0 0 0 01 00
W 0 01
S 96 1 0 0 0 02 00
S 44 0 1 1 0 02 01
W 0 00
S 99 0 1 1 0 02 02
W 1 c8
S 31 0 0 1 0 02 02
S 32 0 0 0 0 02 03
S 33 0 0 1 c8 02 03
W 1 00
W 2 00
S 42 0 0 0 0 02 03
W 2 01
S 43 0 0 1 0 02 03

/* test/uart_loop_tb.sv */
`timescale 1ns/1ps

module uart_loop_tb;

    // limits in clock cycles
    localparam int ECHO_TIMEOUT = 200;
    localparam int QUIET_WIN    = 150;
    localparam int SETTLE       = 24;
    localparam int WATCHDOG     = 20000;

    logic                        clk;
    logic                        rst;
    logic                        rx;
    logic                        tx;
    logic                        cfg_we;
    uart_loop_pkg::cfg_addr_e    cfg_addr;
    logic [7:0]                  cfg_wdata;
    logic                        tx_busy;
    logic [7:0]                  parity_drops;
    logic [7:0]                  overrun_drops;

    int cyc = 0;
    int mismatches = 0;
    int timeouts = 0;
    int other_errs = 0;
    // cycle of the last echo stop bit centre
    int last_end = 0;
    // mode the DUT should be in, tracked from the writes
    uart_loop_pkg::parity_mode_e cur_par = uart_loop_pkg::PARITY_NONE;

    uart_loop_top dut_i (
        .clk           (clk),
        .rst           (rst),
        .rx            (rx),
        .tx            (tx),
        .cfg_we        (cfg_we),
        .cfg_addr      (cfg_addr),
        .cfg_wdata     (cfg_wdata),
        .tx_busy       (tx_busy),
        .parity_drops  (parity_drops),
        .overrun_drops (overrun_drops)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk) begin
        cyc <= cyc + 1;
    end

    // even mode: data plus parity hold an even number of ones
    function automatic logic parity_of(input logic [7:0] b,
                                       input uart_loop_pkg::parity_mode_e m);
        logic p;
        p = ^b;
        if (m == uart_loop_pkg::PARITY_ODD) begin
            p = ~p;
        end
        return p;
    endfunction

    task automatic send_bit(input logic b);
        rx = b;
        repeat (uart_loop_pkg::CLKS_PER_BIT) begin
            @(posedge clk);
            #1;
        end
    endtask

    // start, data lsb first, optional parity, stop
    task automatic send_frame(input logic [7:0] b, input logic corrupt);
        send_bit(1'b0);
        for (int i = 0; i < uart_loop_pkg::DATA_W; i++) begin
            send_bit(b[i]);
        end
        if (cur_par != uart_loop_pkg::PARITY_NONE) begin
            send_bit(parity_of(b, cur_par) ^ corrupt);
        end
        send_bit(1'b1);
    endtask

    task automatic write_cfg(input logic [1:0] addr, input logic [7:0] data);
        cfg_we    = 1'b1;
        cfg_addr  = uart_loop_pkg::cfg_addr_e'(addr);
        cfg_wdata = data;
        @(posedge clk);
        #1;
        cfg_we = 1'b0;
        if (uart_loop_pkg::cfg_addr_e'(addr) == uart_loop_pkg::CFG_PARITY) begin
            // unknown codes read as no parity
            case (data[1:0])
                2'd1:    cur_par = uart_loop_pkg::PARITY_EVEN;
                2'd2:    cur_par = uart_loop_pkg::PARITY_ODD;
                default: cur_par = uart_loop_pkg::PARITY_NONE;
            endcase
        end
    endtask

    // samples at negedge, away from the DUT's register updates
    task automatic capture_echo(input logic [7:0] exp_b, input int min_idle);
        int         n;
        int         idle;
        logic [7:0] got;
        n = 0;
        while (tx !== 1'b0 && n < ECHO_TIMEOUT) begin
            @(negedge clk);
            n++;
        end
        if (tx !== 1'b0) begin
            $display("timeout: no echo frame started on tx within %0d cycles", ECHO_TIMEOUT);
            timeouts++;
            return;
        end
        idle = cyc - last_end;
        if (min_idle > 0) begin
            assert (idle >= min_idle) else begin
                $display("[FAIL] tx idle cycles: expected >= 0x%0h, got 0x%0h", min_idle, idle);
                mismatches++;
            end
        end
        // move to the centre of the start bit
        repeat (uart_loop_pkg::CLKS_PER_BIT / 2) @(negedge clk);
        assert (tx === 1'b0) else begin
            $display("[FAIL] tx start bit: expected 0x0, got 0x%0h", tx);
            mismatches++;
        end
        // transmitter reports busy while its frame is on the line
        assert (tx_busy === 1'b1) else begin
            $display("[FAIL] tx_busy: expected 0x1, got 0x%0h", tx_busy);
            mismatches++;
        end
        for (int i = 0; i < uart_loop_pkg::DATA_W; i++) begin
            repeat (uart_loop_pkg::CLKS_PER_BIT) @(negedge clk);
            got[i] = tx;
        end
        assert (got === exp_b) else begin
            $display("[FAIL] tx data: expected 0x%02h, got 0x%02h", exp_b, got);
            mismatches++;
        end
        if (cur_par != uart_loop_pkg::PARITY_NONE) begin
            repeat (uart_loop_pkg::CLKS_PER_BIT) @(negedge clk);
            assert (tx === parity_of(exp_b, cur_par)) else begin
                $display("[FAIL] tx parity bit: expected 0x%0h, got 0x%0h",
                         parity_of(exp_b, cur_par), tx);
                mismatches++;
            end
        end
        repeat (uart_loop_pkg::CLKS_PER_BIT) @(negedge clk);
        assert (tx === 1'b1) else begin
            $display("[FAIL] tx stop bit: expected 0x1, got 0x%0h", tx);
            mismatches++;
        end
        last_end = cyc;
    endtask

    // tx must stay high for the whole window
    task automatic expect_quiet(input int win);
        int   n;
        logic seen;
        n = 0;
        seen = 1'b0;
        while (n < win && !seen) begin
            @(negedge clk);
            n++;
            assert (tx === 1'b1) else begin
                $display("[FAIL] tx: expected idle 0x1, got 0x%0h", tx);
                mismatches++;
                seen = 1'b1;
            end
        end
    endtask

    task automatic check_counters(input logic [7:0] exp_p, input logic [7:0] exp_o);
        assert (parity_drops === exp_p) else begin
            $display("[FAIL] parity_drops: expected 0x%02h, got 0x%02h", exp_p, parity_drops);
            mismatches++;
        end
        assert (overrun_drops === exp_o) else begin
            $display("[FAIL] overrun_drops: expected 0x%02h, got 0x%02h", exp_o, overrun_drops);
            mismatches++;
        end
    endtask

    task automatic run_send(input logic [7:0] b, input logic corrupt, input logic b2b,
                            input logic echo, input int min_idle,
                            input logic [7:0] exp_p, input logic [7:0] exp_o);
        fork
            begin
                send_frame(b, corrupt);
                // second frame follows with no idle time
                if (b2b) begin
                    send_frame(b, corrupt);
                end
            end
            begin
                if (echo) begin
                    capture_echo(b, min_idle);
                end else begin
                    expect_quiet(QUIET_WIN);
                end
            end
        join
        // no stray second echo, counters settle
        expect_quiet(SETTLE);
        // every frame has ended by now
        assert (tx_busy === 1'b0) else begin
            $display("[FAIL] tx_busy: expected 0x0, got 0x%0h", tx_busy);
            mismatches++;
        end
        check_counters(exp_p, exp_o);
    endtask

    initial begin
        repeat (WATCHDOG) @(posedge clk);
        $display("watchdog expired before the case file finished");
        $display("sim failed");
        $finish;
    end

    initial begin
        int         fd;
        int         r;
        int         cases;
        int         min_idle;
        string      line;
        byte        kind;
        logic [7:0] f_byte;
        logic [7:0] f_corrupt;
        logic [7:0] f_b2b;
        logic [7:0] f_echo;
        logic [7:0] f_p;
        logic [7:0] f_o;
        cases     = 0;
        rst       = 1'b1;
        rx        = 1'b1;
        cfg_we    = 1'b0;
        cfg_addr  = uart_loop_pkg::CFG_PARITY;
        cfg_wdata = 8'h00;
        repeat (2) @(posedge clk);
        #1;
        rst = 1'b0;

        fd = $fopen("test/uart_loop_cases.txt", "r");
        if (fd == 0) begin
            $display("could not open the case file test/uart_loop_cases.txt");
            other_errs++;
        end else begin
            while (!$feof(fd)) begin
                line = "";
                r = $fgets(line, fd);
                if (r > 0) begin
                    kind = line.getc(0);
                    // '#' and blank lines skipped
                    if (kind == "W") begin
                        r = $sscanf(line, "%c %h %h", kind, f_byte, f_p);
                        @(posedge clk);
                        #1;
                        write_cfg(f_byte[1:0], f_p);
                    end else if (kind == "S") begin
                        r = $sscanf(line, "%c %h %h %h %h %h %h %h", kind, f_byte,
                                    f_corrupt, f_b2b, f_echo, min_idle, f_p, f_o);
                        if (r == 8) begin
                            @(posedge clk);
                            #1;
                            run_send(f_byte, f_corrupt[0], f_b2b[0], f_echo[0],
                                     min_idle, f_p, f_o);
                            cases++;
                        end else begin
                            $display("malformed send line in the case file: %s", line);
                            other_errs++;
                        end
                    end
                end
            end
            $fclose(fd);
        end
        if (cases == 0) begin
            $display("no send cases were run");
            other_errs++;
        end

        $display("cases %0d, errors %0d: mismatches %0d, timeouts %0d, other %0d", cases,
                 mismatches + timeouts + other_errs, mismatches, timeouts, other_errs);
        if (mismatches + timeouts + other_errs == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule
